// File: src/sr_cfg.svh
/* Build-time settings for the status capture side channel:
   synchronizer depth, group widths, slow-frame divider and frame gap */
`ifndef SR_CFG_SVH
`define SR_CFG_SVH

// Flip-flops in each bit synchronizer
`define SR_SYNC_STAGE 3

// Fast status group width
`define SR_FSR_W 4

// Slow status group width
`define SR_SSR_W 8

// Slow group goes out once every this many frames
`define SR_SSR_DIV 4

// Idle cycles after each frame
`define SR_GAP 3

`endif

// File: src/hip_sr_pkg.sv
/* Status data types shared by capture, serializer and top */
`default_nettype none

`include "sr_cfg.svh"

package hip_sr_pkg;

  // Fast status group, sampled every frame
  typedef logic [`SR_FSR_W-1:0] fsr_t;

  // Slow status group, sampled in slow frames only
  typedef logic [`SR_SSR_W-1:0] ssr_t;

  // Both groups as seen at the hard IP boundary
  typedef struct packed {
    fsr_t fsr;
    ssr_t ssr;
  } hip_status_t;

endpackage

`default_nettype wire

// File: src/sr_ctrl_pkg.sv
/* Control types for the frame sequencer: state enum, command to the
   serializer and configuration levels */
`default_nettype none

`include "sr_cfg.svh"

package sr_ctrl_pkg;

  // Frame sequencer states
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    LATCH,
    SHIFT_FSR,
    SHIFT_SSR,
    GAP
  } sr_state_e;

  // Per-cycle command to the serializer
  typedef struct packed {
    logic latch;
    logic shift;
    logic first;
    logic slow;
  } sr_cmd_t;

  // Static configuration levels
  typedef struct packed {
    logic [`SR_FSR_W-1:0] fsr_rst_val;
    logic                 enable;
  } sr_cfg_t;

endpackage

`default_nettype wire

// File: src/async_capture_bit.sv
/* Single status bit: synchronizer chain plus load-sampled holding
   register, both with a selectable reset value */
`timescale 1ns/1ps
`default_nettype none

module async_capture_bit #(
  parameter int SYNC_STAGE = 3,
  parameter bit RESET_VAL  = 1'b0
) (
  input  wire  tx_osc_clk,
  input  wire  rst_n,
  input  wire  data_in,
  input  wire  load,
  output logic data_out
);

  logic [SYNC_STAGE-1:0] sync_q;

  // Synchronizer chain, data enters at bit 0
  always_ff @(posedge tx_osc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= {SYNC_STAGE{RESET_VAL}};
    end else begin
      sync_q <= {sync_q[SYNC_STAGE-2:0], data_in};
    end
  end

  // Holding register, updated only on load
  always_ff @(posedge tx_osc_clk or negedge rst_n) begin
    if (!rst_n) begin
      data_out <= RESET_VAL;
    end else if (load) begin
      data_out <= sync_q[SYNC_STAGE-1];
    end
  end

endmodule

`default_nettype wire

// File: src/hip_async_capture.sv
/* Capture block for the fast and slow status groups; each fast bit is
   held twice and the configured reset value picks the copy */
`timescale 1ns/1ps
`default_nettype none

`include "sr_cfg.svh"

module hip_async_capture (
  input  wire                      tx_osc_clk,
  input  wire                      rst_n,
  input  hip_sr_pkg::hip_status_t  hip_status,
  input  wire  [`SR_FSR_W-1:0]     fsr_rst_val,
  input  wire                      fsr_load,
  input  wire                      ssr_load,
  output hip_sr_pkg::hip_status_t  captured
);

  wire [`SR_FSR_W-1:0] fsr_rst1;
  wire [`SR_FSR_W-1:0] fsr_rst0;
  wire [`SR_FSR_W-1:0] fsr_sel;
  wire [`SR_SSR_W-1:0] ssr_cap;

  // Fast group
  for (genvar i = 0; i < `SR_FSR_W; i++) begin : g_fsr
    async_capture_bit #(
      .SYNC_STAGE (`SR_SYNC_STAGE),
      .RESET_VAL  (1'b1)
    ) u_rst1 (
      .tx_osc_clk (tx_osc_clk),
      .rst_n      (rst_n),
      .data_in    (hip_status.fsr[i]),
      .load       (fsr_load),
      .data_out   (fsr_rst1[i])
    );

    async_capture_bit #(
      .SYNC_STAGE (`SR_SYNC_STAGE),
      .RESET_VAL  (1'b0)
    ) u_rst0 (
      .tx_osc_clk (tx_osc_clk),
      .rst_n      (rst_n),
      .data_in    (hip_status.fsr[i]),
      .load       (fsr_load),
      .data_out   (fsr_rst0[i])
    );

    // Copy whose reset value matches the configured one
    assign fsr_sel[i] = fsr_rst_val[i] ? fsr_rst1[i] : fsr_rst0[i];
  end

  // Slow group, always resets to zero
  for (genvar j = 0; j < `SR_SSR_W; j++) begin : g_ssr
    async_capture_bit #(
      .SYNC_STAGE (`SR_SYNC_STAGE),
      .RESET_VAL  (1'b0)
    ) u_cap (
      .tx_osc_clk (tx_osc_clk),
      .rst_n      (rst_n),
      .data_in    (hip_status.ssr[j]),
      .load       (ssr_load),
      .data_out   (ssr_cap[j])
    );
  end

  assign captured.fsr = fsr_sel;
  assign captured.ssr = ssr_cap;

endmodule

`default_nettype wire

// File: src/sr_load_ctrl.sv
/* Frame sequencer: issues load strobes to the capture block and
   latch/shift commands to the serializer */
`timescale 1ns/1ps
`default_nettype none

`include "sr_cfg.svh"

module sr_load_ctrl (
  input  wire                   tx_osc_clk,
  input  wire                   rst_n,
  input  wire                   enable,
  output logic                  fsr_load,
  output logic                  ssr_load,
  output sr_ctrl_pkg::sr_cmd_t  cmd
);

  // Counter must reach the longest of shift and gap phases
  localparam int CNT_A = (`SR_FSR_W > `SR_SSR_W) ? `SR_FSR_W : `SR_SSR_W;
  localparam int CNT_N = (CNT_A > `SR_GAP) ? CNT_A : `SR_GAP;
  localparam int CNT_W = (CNT_N > 1) ? $clog2(CNT_N) : 1;
  localparam int FRM_W = (`SR_SSR_DIV > 1) ? $clog2(`SR_SSR_DIV) : 1;

  sr_ctrl_pkg::sr_state_e state_q;
  sr_ctrl_pkg::sr_state_e state_d;
  logic [CNT_W-1:0]       bit_cnt_q;
  logic [FRM_W-1:0]       frm_cnt_q;
  logic                   slow_frame;
  logic                   counting;

  assign slow_frame = (frm_cnt_q == '0);

  // Only the shift and gap phases use the bit counter
  assign counting = (state_q == sr_ctrl_pkg::SHIFT_FSR) ||
                    (state_q == sr_ctrl_pkg::SHIFT_SSR) ||
                    (state_q == sr_ctrl_pkg::GAP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      sr_ctrl_pkg::IDLE: begin
        if (enable) begin
          state_d = sr_ctrl_pkg::LOAD;
        end
      end
      sr_ctrl_pkg::LOAD:  state_d = sr_ctrl_pkg::LATCH;
      sr_ctrl_pkg::LATCH: state_d = sr_ctrl_pkg::SHIFT_FSR;
      sr_ctrl_pkg::SHIFT_FSR: begin
        if (bit_cnt_q == CNT_W'(`SR_FSR_W - 1)) begin
          state_d = slow_frame ? sr_ctrl_pkg::SHIFT_SSR : sr_ctrl_pkg::GAP;
        end
      end
      sr_ctrl_pkg::SHIFT_SSR: begin
        if (bit_cnt_q == CNT_W'(`SR_SSR_W - 1)) begin
          state_d = sr_ctrl_pkg::GAP;
        end
      end
      sr_ctrl_pkg::GAP: begin
        // Enable is only looked at here, so a running frame completes
        if (bit_cnt_q == CNT_W'(`SR_GAP - 1)) begin
          state_d = enable ? sr_ctrl_pkg::LOAD : sr_ctrl_pkg::IDLE;
        end
      end
      default: state_d = sr_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge tx_osc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= sr_ctrl_pkg::IDLE;
      bit_cnt_q <= '0;
      frm_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (!counting || state_d != state_q) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      // Restart at a slow frame whenever the sequencer idles
      if (state_q == sr_ctrl_pkg::IDLE) begin
        frm_cnt_q <= '0;
      end else if (state_q != sr_ctrl_pkg::GAP && state_d == sr_ctrl_pkg::GAP) begin
        frm_cnt_q <= (frm_cnt_q == FRM_W'(`SR_SSR_DIV - 1)) ? '0 : frm_cnt_q + 1'b1;
      end
    end
  end

  assign fsr_load  = (state_q == sr_ctrl_pkg::LOAD);
  assign ssr_load  = (state_q == sr_ctrl_pkg::LOAD) && slow_frame;
  assign cmd.latch = (state_q == sr_ctrl_pkg::LATCH);
  assign cmd.shift = (state_q == sr_ctrl_pkg::SHIFT_FSR) ||
                     (state_q == sr_ctrl_pkg::SHIFT_SSR);
  assign cmd.first = (state_q == sr_ctrl_pkg::SHIFT_FSR) && (bit_cnt_q == '0);
  assign cmd.slow  = (state_q == sr_ctrl_pkg::SHIFT_SSR);

endmodule

`default_nettype wire

// File: src/sr_serializer.sv
/* Serializer: latches the captured groups into shift registers and
   sends them LSB first with frame and slow markers */
`timescale 1ns/1ps
`default_nettype none

module sr_serializer (
  input  wire                      tx_osc_clk,
  input  wire                      rst_n,
  input  hip_sr_pkg::hip_status_t  captured,
  input  sr_ctrl_pkg::sr_cmd_t     cmd,
  output logic                     sr_data,
  output logic                     sr_valid,
  output logic                     sr_frame,
  output logic                     sr_slow
);

  hip_sr_pkg::fsr_t fsr_sh;
  hip_sr_pkg::ssr_t ssr_sh;

  // Shift registers for both groups
  always_ff @(posedge tx_osc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fsr_sh <= '0;
      ssr_sh <= '0;
    end else if (cmd.latch) begin
      fsr_sh <= captured.fsr;
      ssr_sh <= captured.ssr;
    end else if (cmd.shift) begin
      if (cmd.slow) begin
        ssr_sh <= ssr_sh >> 1;
      end else begin
        fsr_sh <= fsr_sh >> 1;
      end
    end
  end

  // Output bit and markers one cycle behind the command
  always_ff @(posedge tx_osc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sr_data  <= 1'b0;
      sr_valid <= 1'b0;
      sr_frame <= 1'b0;
      sr_slow  <= 1'b0;
    end else begin
      sr_valid <= cmd.shift;
      sr_frame <= cmd.shift & cmd.first;
      sr_slow  <= cmd.shift & cmd.slow;
      if (cmd.shift) begin
        sr_data <= cmd.slow ? ssr_sh[0] : fsr_sh[0];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/hip_sr_top.sv
/* Status side channel top: sequencer, capture block and serializer */
`timescale 1ns/1ps
`default_nettype none

module hip_sr_top (
  input  wire                      tx_osc_clk,
  input  wire                      rst_n,
  input  hip_sr_pkg::hip_status_t  hip_status,
  input  sr_ctrl_pkg::sr_cfg_t     cfg,
  output hip_sr_pkg::hip_status_t  status_out,
  output logic                     sr_data,
  output logic                     sr_valid,
  output logic                     sr_frame,
  output logic                     sr_slow
);

  logic                 fsr_load;
  logic                 ssr_load;
  sr_ctrl_pkg::sr_cmd_t cmd;

  sr_load_ctrl u_ctrl (
    .tx_osc_clk (tx_osc_clk),
    .rst_n      (rst_n),
    .enable     (cfg.enable),
    .fsr_load   (fsr_load),
    .ssr_load   (ssr_load),
    .cmd        (cmd)
  );

  // Captured groups also leave the top as status_out
  hip_async_capture u_capture (
    .tx_osc_clk  (tx_osc_clk),
    .rst_n       (rst_n),
    .hip_status  (hip_status),
    .fsr_rst_val (cfg.fsr_rst_val),
    .fsr_load    (fsr_load),
    .ssr_load    (ssr_load),
    .captured    (status_out)
  );

  sr_serializer u_serializer (
    .tx_osc_clk (tx_osc_clk),
    .rst_n      (rst_n),
    .captured   (status_out),
    .cmd        (cmd),
    .sr_data    (sr_data),
    .sr_valid   (sr_valid),
    .sr_frame   (sr_frame),
    .sr_slow    (sr_slow)
  );

endmodule

`default_nettype wire

// File: testbench/hip_sr_tb.sv
/* Testbench for the status side channel: clock, reset, stimulus,
   frame collector, assertions, watchdog and reporting */
`timescale 1ns/1ps
`default_nettype none

`include "sr_cfg.svh"

module hip_sr_tb;

  localparam int CLK_HALF  = 20;
  localparam int RESET_CYC = 16;
  localparam int FAST_LEN  = 2 + `SR_FSR_W + `SR_GAP;
  localparam int SLOW_LEN  = FAST_LEN + `SR_SSR_W;
  localparam int N_TESTS   = 6;
  localparam int N_RAND    = 20;
  localparam int N_LOG     = 12;
  localparam int FRAME_TMO = 4 * SLOW_LEN;
  // Eight slow frames per test, each random value counts as two tests
  localparam int WATCHDOG_CYC = 2 * RESET_CYC + (N_TESTS + 2 * N_RAND) * 8 * SLOW_LEN;

  localparam logic [`SR_FSR_W-1:0] RST_VAL_A = 'hA;
  localparam logic [`SR_FSR_W-1:0] RST_VAL_B = 'h5;

  // One received frame, bits in arrival order
  typedef struct packed {
    hip_sr_pkg::hip_status_t bits;
    logic [7:0]              fsr_n;
    logic [7:0]              ssr_n;
  } frame_t;

  logic                    tx_osc_clk;
  logic                    rst_n;
  hip_sr_pkg::hip_status_t hip_status;
  sr_ctrl_pkg::sr_cfg_t    cfg;
  hip_sr_pkg::hip_status_t status_out;
  logic                    sr_data;
  logic                    sr_valid;
  logic                    sr_frame;
  logic                    sr_slow;

  integer seed = 32'h4f8f8391;
  int     err_cnt;
  int     test_err_base;
  int     tests_ok;
  int     tests_bad;
  int     rx_count;
  int     enable_base;
  logic   in_frame;
  frame_t cur;
  frame_t frame_q[$];
  frame_t frame_log [N_LOG];

  hip_sr_top hip_sr_top_i (
    .tx_osc_clk (tx_osc_clk),
    .rst_n      (rst_n),
    .hip_status (hip_status),
    .cfg        (cfg),
    .status_out (status_out),
    .sr_data    (sr_data),
    .sr_valid   (sr_valid),
    .sr_frame   (sr_frame),
    .sr_slow    (sr_slow)
  );

  initial tx_osc_clk = 1'b0;
  always #CLK_HALF tx_osc_clk = ~tx_osc_clk;

  // Marker rules on the serial stream
  assert property (@(posedge tx_osc_clk) disable iff (!rst_n)
                   sr_frame |-> (sr_valid && !sr_slow))
    else begin
      $display("Frame marker seen without a valid fast bit at %0t", $time);
      err_cnt++;
    end

  assert property (@(posedge tx_osc_clk) disable iff (!rst_n) sr_slow |-> sr_valid)
    else begin
      $display("Slow marker seen without a valid bit at %0t", $time);
      err_cnt++;
    end

  // Frame collector, outputs sampled mid-cycle
  always @(negedge tx_osc_clk) begin
    if (!rst_n) begin
      in_frame = 1'b0;
      rx_count = 0;
    end else if (sr_valid) begin
      if (sr_frame) begin
        in_frame = 1'b1;
        cur = '0;
      end
      assert (in_frame) else begin
        $display("Serial bit without a frame marker at %0t", $time);
        err_cnt++;
      end
      if (sr_slow) begin
        if (cur.ssr_n < `SR_SSR_W) begin
          cur.bits.ssr[cur.ssr_n] = sr_data;
        end
        cur.ssr_n = cur.ssr_n + 1'b1;
      end else begin
        if (cur.fsr_n < `SR_FSR_W) begin
          cur.bits.fsr[cur.fsr_n] = sr_data;
        end
        cur.fsr_n = cur.fsr_n + 1'b1;
      end
    end else if (in_frame) begin
      // First idle cycle closes the frame
      in_frame = 1'b0;
      frame_q.push_back(cur);
      rx_count++;
    end
  end

  function automatic hip_sr_pkg::hip_status_t rand_status();
    logic [31:0] r;
    r = $random(seed);
    return r[$bits(hip_sr_pkg::hip_status_t)-1:0];
  endfunction

  function automatic bit is_slow_frame(input int idx);
    return (idx % `SR_SSR_DIV) == 0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      $display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
      err_cnt++;
    end
  endtask

  task automatic check_reset_state(input logic [`SR_FSR_W-1:0] rst_val);
    check_value("status_out.fsr", rst_val, status_out.fsr);
    check_value("status_out.ssr", 0, status_out.ssr);
    check_value("sr_valid", 0, sr_valid);
    check_value("sr_frame", 0, sr_frame);
    check_value("sr_slow", 0, sr_slow);
  endtask

  // Reset with the given fast reset value, then a few idle cycles
  task automatic reset_and_check(input logic [`SR_FSR_W-1:0] rst_val);
    rst_n = 1'b0;
    cfg.fsr_rst_val = rst_val;
    repeat (RESET_CYC) begin
      @(negedge tx_osc_clk);
      check_reset_state(rst_val);
    end
    rst_n = 1'b1;
    repeat (8) begin
      @(negedge tx_osc_clk);
      check_reset_state(rst_val);
    end
  endtask

  task automatic wait_frame_start(output bit ok);
    int waited;
    waited = 0;
    ok = 1'b0;
    while (!ok && waited < FRAME_TMO) begin
      @(negedge tx_osc_clk);
      ok = sr_frame;
      waited++;
    end
    assert (ok) else begin
      $display("Missing frame: no frame started within %0d cycles", FRAME_TMO);
      err_cnt++;
    end
  endtask

  task automatic get_frame(output frame_t fr, output bit ok);
    int waited;
    waited = 0;
    while (frame_q.size() == 0 && waited < FRAME_TMO) begin
      @(negedge tx_osc_clk);
      waited++;
    end
    ok = (frame_q.size() != 0);
    assert (ok) else begin
      $display("Missing frame: none completed within %0d cycles", FRAME_TMO);
      err_cnt++;
    end
    if (ok) begin
      fr = frame_q.pop_front();
    end else begin
      fr = '0;
    end
  endtask

  task automatic check_frame(input frame_t fr, input hip_sr_pkg::hip_status_t exp,
                             input bit slow);
    check_value("sr_data fast bit count", `SR_FSR_W, fr.fsr_n);
    check_value("sr_data fast bits", exp.fsr, fr.bits.fsr);
    check_value("sr_slow bit count", slow ? `SR_SSR_W : 0, fr.ssr_n);
    if (slow) begin
      check_value("sr_data slow bits", exp.ssr, fr.bits.ssr);
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (err_cnt == test_err_base) begin
      tests_ok++;
      $display("Test %0d %s: pass", num, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s: fail with %0d errors", num, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    frame_t                  fr;
    hip_sr_pkg::hip_status_t held;
    hip_sr_pkg::hip_status_t next_st;
    bit                      ok;
    int                      idx;
    int                      base;

    err_cnt       = 0;
    test_err_base = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    enable_base   = 0;
    rst_n         = 1'b0;
    cfg           = '0;
    hip_status    = rand_status();
    held          = hip_status;

    reset_and_check(RST_VAL_A);
    reset_and_check(RST_VAL_B);
    finish_test(1, "reset values");

    frame_q.delete();
    enable_base = rx_count;
    cfg.enable = 1'b1;
    for (idx = 0; idx < N_LOG; idx++) begin
      get_frame(fr, ok);
      frame_log[idx] = fr;
      check_value("sr_data fast bit count", `SR_FSR_W, fr.fsr_n);
      check_value("sr_data fast bits", held.fsr, fr.bits.fsr);
    end
    finish_test(2, "fast group every frame");

    for (idx = 0; idx < N_LOG; idx++) begin
      check_frame(frame_log[idx], held, is_slow_frame(idx));
    end
    finish_test(3, "slow group every 4th frame");

    // New value driven while a frame is on the wire
    frame_q.delete();
    next_st = ~held;
    wait_frame_start(ok);
    idx = rx_count - enable_base;
    hip_status = next_st;
    while (sr_valid) begin
      check_value("status_out", held, status_out);
      @(negedge tx_osc_clk);
    end
    check_value("status_out", held, status_out);
    get_frame(fr, ok);
    check_frame(fr, held, is_slow_frame(idx));
    idx++;
    wait_frame_start(ok);
    check_value("status_out.fsr", next_st.fsr, status_out.fsr);
    while (!is_slow_frame(idx)) begin
      check_value("status_out.ssr", held.ssr, status_out.ssr);
      get_frame(fr, ok);
      check_frame(fr, next_st, 1'b0);
      idx++;
      wait_frame_start(ok);
      check_value("status_out.fsr", next_st.fsr, status_out.fsr);
    end
    check_value("status_out.ssr", next_st.ssr, status_out.ssr);
    get_frame(fr, ok);
    check_frame(fr, next_st, 1'b1);
    finish_test(4, "input change between frames");

    frame_q.delete();
    wait_frame_start(ok);
    cfg.enable = 1'b0;
    base = rx_count;
    repeat (3 * SLOW_LEN) begin
      @(negedge tx_osc_clk);
      if (rx_count > base) begin
        check_value("sr_valid", 0, sr_valid);
      end
    end
    assert (rx_count - base <= 1) else begin
      $display("%0d frames completed after enable dropped", rx_count - base);
      err_cnt++;
    end
    finish_test(5, "enable drop");

    frame_q.delete();
    enable_base = rx_count;
    cfg.enable = 1'b1;
    repeat (N_RAND) begin
      next_st = rand_status();
      wait_frame_start(ok);
      idx = rx_count - enable_base;
      hip_status = next_st;
      // Frame in flight still carries the previous value
      get_frame(fr, ok);
      repeat (2 * `SR_SSR_DIV) begin
        idx++;
        get_frame(fr, ok);
        check_frame(fr, next_st, is_slow_frame(idx));
      end
    end
    finish_test(6, "random status values");

    $display("Summary: %0d of %0d tests ok, %0d bad, %0d check errors",
             tests_ok, N_TESTS, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYC) @(posedge tx_osc_clk);
    $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYC);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+src
src/hip_sr_pkg.sv
src/sr_ctrl_pkg.sv
src/async_capture_bit.sv
src/hip_async_capture.sv
src/sr_load_ctrl.sv
src/sr_serializer.sv
src/hip_sr_top.sv
testbench/hip_sr_tb.sv
